// ==== hw/owt_pkg.sv ====
// one-wire bus receiver
// shared constants and types
`default_nettype none

package owt_pkg;

    // ==============================
    // frame field widths
    // ==============================
    localparam int OWT_CMD_BITS  = 8;
    localparam int OWT_DATA_BITS = 16;
    localparam int OWT_CRC_BITS  = 8;
    localparam int OWT_TAIL_BITS = 4;

    // first sample in the msb
    localparam logic [OWT_TAIL_BITS-1:0] OWT_TAIL_PATTERN = 4'b1100;

    // three high pulses in the preamble
    localparam int OWT_SYNC_EDGES = 6;

    // x^8 + x^2 + x + 1, zero init, msb first
    localparam logic [OWT_CRC_BITS-1:0] OWT_CRC_POLY = 8'h07;

    // ==============================
    // counter widths
    // ==============================
    localparam int OWT_HALF_CNT_W = 8;
    localparam int OWT_BIT_CNT_W  = 5;
    localparam int OWT_ERR_CNT_W  = 5;

    // ==============================
    // error counter tables
    // ==============================
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_MAX  = 5'd31;
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_INIT = 5'd0;

    // add per bad frame, index is config[3:2]
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_ADD_TABLE [0:3] = '{
        5'd1, 5'd2, 5'd4, 5'd8
    };

    // subtract per good frame, index is config[1:0]
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_COR_SUB_TABLE [0:3] = '{
        5'd1, 5'd2, 5'd3, 5'd4
    };

    // receiver states
    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        DATA,
        CRC,
        END_TAIL
    } owt_rx_state_e;

endpackage

`default_nettype wire

// ==== hw/owt_line_sampler.sv ====
// one-wire line sampler
`default_nettype none
`timescale 1ns/1ns

module owt_line_sampler (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_owt_rx,
    input  owt_pkg::owt_rx_state_e i_state,
    output logic                   o_edge,
    output logic                   o_rise,
    output logic                   o_half_strobe,
    output logic                   o_sample_bit
);
    import owt_pkg::*;

    logic                      rx_meta;
    logic                      rx_sync;
    logic                      rx_dly;
    logic [OWT_HALF_CNT_W-1:0] intv_cnt;
    logic [OWT_HALF_CNT_W-1:0] half_len;
    logic [OWT_HALF_CNT_W-1:0] tmr;
    logic                      tmr_run;
    logic                      in_head;
    logic                      track;

    // two-flop synchronizer, third flop for edge detect
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b0;
            rx_sync <= 1'b0;
            rx_dly  <= 1'b0;
        end else begin
            rx_meta <= i_owt_rx;
            rx_sync <= rx_meta;
            rx_dly  <= rx_sync;
        end
    end

    assign o_edge       = rx_sync ^ rx_dly;
    assign o_rise       = rx_sync & ~rx_dly;
    assign o_sample_bit = rx_sync;

    assign in_head = (i_state == SYNC_HEAD);
    assign track   = (i_state != IDLE) && (i_state != SYNC_HEAD);

    // ==============================
    // half-bit length from preamble
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            intv_cnt <= OWT_HALF_CNT_W'(1);
            half_len <= '0;
        end else begin
            if (o_edge) begin
                intv_cnt <= OWT_HALF_CNT_W'(1);
            end else if (intv_cnt != '1) begin
                intv_cnt <= intv_cnt + OWT_HALF_CNT_W'(1);
            end
            // keep the longest interval seen in the head
            if (i_state == IDLE) begin
                half_len <= '0;
            end else if (in_head && o_edge && (intv_cnt > half_len)) begin
                half_len <= intv_cnt;
            end
        end
    end

    // ==============================
    // mid half-bit strobe
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmr_run <= 1'b0;
            tmr     <= '0;
        end else if (!track) begin
            tmr_run <= 1'b0;
            tmr     <= '0;
        end else if (o_edge) begin
            // realign on every edge
            tmr_run <= 1'b1;
            tmr     <= (half_len >> 1) - OWT_HALF_CNT_W'(1);
        end else if (tmr_run) begin
            if (tmr == '0) begin
                tmr <= half_len - OWT_HALF_CNT_W'(1);
            end else begin
                tmr <= tmr - OWT_HALF_CNT_W'(1);
            end
        end
    end

    assign o_half_strobe = tmr_run && (tmr == '0);

endmodule

`default_nettype wire

// ==== hw/owt_mcst_decoder.sv ====
// manchester bit decoder
`default_nettype none
`timescale 1ns/1ns

module owt_mcst_decoder (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_mcst_en,
    input  logic i_half_strobe,
    input  logic i_sample_bit,
    output logic o_bit_vld,
    output logic o_bit_val,
    output logic o_invalid
);

    logic phase;
    logic first_half;
    logic second;

    // high when the next strobe is the second half of a bit
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase <= 1'b0;
        end else if (!i_mcst_en) begin
            phase <= 1'b0;
        end else if (i_half_strobe) begin
            phase <= ~phase;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_mcst_en && i_half_strobe && !phase) begin
            first_half <= i_sample_bit;
        end
    end

    assign second = i_mcst_en & i_half_strobe & phase;

    // high-low is 1, low-high is 0
    assign o_bit_vld = second & (first_half ^ i_sample_bit);
    assign o_bit_val = first_half;
    assign o_invalid = second & ~(first_half ^ i_sample_bit);

endmodule

`default_nettype wire

// ==== hw/owt_crc8_serial.sv ====
// bit-serial crc-8
`default_nettype none
`timescale 1ns/1ns

module owt_crc8_serial (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_vld,
    input  logic                             i_start,
    input  logic                             i_bit,
    output logic [owt_pkg::OWT_CRC_BITS-1:0] o_crc
);
    import owt_pkg::*;

    logic [OWT_CRC_BITS-1:0] crc_base;
    logic                    fb;

    // start folds the first bit into a cleared register
    assign crc_base = i_start ? '0 : o_crc;
    assign fb       = crc_base[OWT_CRC_BITS-1] ^ i_bit;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= '0;
        end else if (i_vld) begin
            o_crc <= {crc_base[OWT_CRC_BITS-2:0], 1'b0} ^ (fb ? OWT_CRC_POLY : '0);
        end
    end

endmodule

`default_nettype wire

// ==== hw/owt_rx_frame_fsm.sv ====
// one-wire receive frame control
`default_nettype none
`timescale 1ns/1ns

module owt_rx_frame_fsm (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_edge,
    input  logic                              i_rise,
    input  logic                              i_half_strobe,
    input  logic                              i_sample_bit,
    input  logic                              i_bit_vld,
    input  logic                              i_bit_val,
    input  logic                              i_invalid,
    input  logic [owt_pkg::OWT_CRC_BITS-1:0]  i_crc,
    output owt_pkg::owt_rx_state_e            o_state,
    output logic                              o_mcst_en,
    output logic                              o_crc_vld,
    output logic                              o_crc_start,
    output logic                              o_rac_vld,
    output logic                              o_rac_status,
    output logic                              o_rst_wdg,
    output logic [owt_pkg::OWT_CMD_BITS-1:0]  o_rac_cmd,
    output logic [owt_pkg::OWT_DATA_BITS-1:0] o_rac_data,
    output logic [owt_pkg::OWT_CRC_BITS-1:0]  o_rac_crc,
    output logic                              o_frame_done,
    output logic                              o_frame_bad
);
    import owt_pkg::*;

    owt_rx_state_e            state;
    owt_rx_state_e            nxt_state;
    logic [OWT_BIT_CNT_W-1:0] bit_cnt;
    logic [OWT_BIT_CNT_W-1:0] cnt_last;
    logic                     cnt_evt;
    logic                     cnt_hit;
    logic [OWT_TAIL_BITS-1:0] tail_sr;
    logic [OWT_TAIL_BITS-1:0] tail_next;
    logic [OWT_CMD_BITS-1:0]  cmd_sr;
    logic [OWT_DATA_BITS-1:0] data_sr;
    logic [OWT_CRC_BITS-1:0]  crc_sr;
    logic                     tail_shift;
    logic                     abort;
    logic                     end_done;
    logic                     rpt;
    logic                     rpt_bad;
    logic                     bad_q;

    assign o_mcst_en  = (state == CMD) || (state == DATA) || (state == CRC);
    assign tail_shift = i_half_strobe && ((state == SYNC_TAIL) || (state == END_TAIL));
    assign tail_next  = {tail_sr[OWT_TAIL_BITS-2:0], i_sample_bit};
    assign abort      = o_mcst_en & i_invalid;

    // ==============================
    // per-state count and successor
    // ==============================
    always_comb begin
        cnt_last  = OWT_BIT_CNT_W'(OWT_SYNC_EDGES - 1);
        cnt_evt   = 1'b0;
        nxt_state = IDLE;
        case (state)
            SYNC_HEAD: begin
                cnt_evt   = i_edge;
                nxt_state = SYNC_TAIL;
            end
            SYNC_TAIL: begin
                cnt_last  = OWT_BIT_CNT_W'(OWT_TAIL_BITS - 1);
                cnt_evt   = i_half_strobe;
                // bad sync tail drops the frame without a report
                nxt_state = (tail_next == OWT_TAIL_PATTERN) ? CMD : IDLE;
            end
            CMD: begin
                cnt_last  = OWT_BIT_CNT_W'(OWT_CMD_BITS - 1);
                cnt_evt   = i_bit_vld;
                nxt_state = DATA;
            end
            DATA: begin
                cnt_last  = OWT_BIT_CNT_W'(OWT_DATA_BITS - 1);
                cnt_evt   = i_bit_vld;
                nxt_state = CRC;
            end
            CRC: begin
                cnt_last  = OWT_BIT_CNT_W'(OWT_CRC_BITS - 1);
                cnt_evt   = i_bit_vld;
                nxt_state = END_TAIL;
            end
            END_TAIL: begin
                cnt_last = OWT_BIT_CNT_W'(OWT_TAIL_BITS - 1);
                cnt_evt  = i_half_strobe;
            end
            default: ;
        endcase
    end

    assign cnt_hit = (bit_cnt == cnt_last);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else if (state == IDLE) begin
            // first preamble edge already counted
            if (i_rise) begin
                state   <= SYNC_HEAD;
                bit_cnt <= OWT_BIT_CNT_W'(1);
            end
        end else if (abort) begin
            state   <= IDLE;
            bit_cnt <= '0;
        end else if (cnt_evt) begin
            if (cnt_hit) begin
                state   <= nxt_state;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + OWT_BIT_CNT_W'(1);
            end
        end
    end

    // field shift registers, msb first
    always_ff @(posedge i_clk) begin
        if (tail_shift) begin
            tail_sr <= tail_next;
        end
        if (i_bit_vld && (state == CMD)) begin
            cmd_sr <= {cmd_sr[OWT_CMD_BITS-2:0], i_bit_val};
        end
        if (i_bit_vld && (state == DATA)) begin
            data_sr <= {data_sr[OWT_DATA_BITS-2:0], i_bit_val};
        end
        if (i_bit_vld && (state == CRC)) begin
            crc_sr <= {crc_sr[OWT_CRC_BITS-2:0], i_bit_val};
        end
    end

    assign o_crc_vld   = i_bit_vld && ((state == CMD) || (state == DATA));
    assign o_crc_start = i_bit_vld && (state == CMD) && (bit_cnt == '0);

    // ==============================
    // frame report
    // ==============================
    assign end_done = (state == END_TAIL) && i_half_strobe && cnt_hit;
    assign rpt      = abort | end_done;
    assign rpt_bad  = abort | (tail_next != OWT_TAIL_PATTERN) | (crc_sr != i_crc);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rac_vld    <= 1'b0;
            o_rac_status <= 1'b0;
            o_rst_wdg    <= 1'b0;
            bad_q        <= 1'b0;
        end else begin
            o_rac_vld <= rpt;
            o_rst_wdg <= rpt & ~rpt_bad;
            bad_q     <= rpt & rpt_bad;
            if (rpt) begin
                o_rac_status <= rpt_bad;
            end
        end
    end

    assign o_state      = state;
    assign o_rac_cmd    = cmd_sr;
    assign o_rac_data   = data_sr;
    assign o_rac_crc    = crc_sr;
    assign o_frame_done = o_rac_vld;
    assign o_frame_bad  = bad_q;

endmodule

`default_nettype wire

// ==== hw/owt_com_err_monitor.sv ====
// communication error monitor
`default_nettype none
`timescale 1ns/1ns

module owt_com_err_monitor (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_frame_done,
    input  logic       i_frame_bad,
    input  logic       i_comerr_mode,
    input  logic [3:0] i_comerr_config,
    output logic       o_com_err
);
    import owt_pkg::*;

    logic [OWT_ERR_CNT_W-1:0] err_cnt;
    logic [OWT_ERR_CNT_W-1:0] add_val;
    logic [OWT_ERR_CNT_W-1:0] sub_val;
    logic [OWT_ERR_CNT_W:0]   add_sum;
    logic                     alarm;

    assign add_val = OWT_ERR_ADD_TABLE[i_comerr_config[3:2]];
    assign sub_val = OWT_COR_SUB_TABLE[i_comerr_config[1:0]];
    assign add_sum = {1'b0, err_cnt} + {1'b0, add_val};

    // leaky counter, up on bad frames and down on good ones
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_cnt <= OWT_ERR_INIT;
        end else if (i_frame_done && i_frame_bad) begin
            err_cnt <= (add_sum >= {1'b0, OWT_ERR_MAX}) ? OWT_ERR_MAX
                                                        : add_sum[OWT_ERR_CNT_W-1:0];
        end else if (i_frame_done) begin
            err_cnt <= (sub_val >= err_cnt) ? '0 : err_cnt - sub_val;
        end
    end

    // mode 0 threshold, mode 1 empty
    assign alarm = i_comerr_mode ? (err_cnt == '0) : (err_cnt >= add_val);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_com_err <= 1'b1;
        end else begin
            o_com_err <= alarm;
        end
    end

endmodule

`default_nettype wire

// ==== hw/owt_rx_ctrl.sv ====
// one-wire bus receiver top
`default_nettype none
`timescale 1ns/1ns

module owt_rx_ctrl (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_owt_rx,
    input  logic                              i_comerr_mode,
    input  logic [3:0]                        i_comerr_config,
    output logic                              o_rac_vld,
    output logic [owt_pkg::OWT_CMD_BITS-1:0]  o_rac_cmd,
    output logic [owt_pkg::OWT_DATA_BITS-1:0] o_rac_data,
    output logic [owt_pkg::OWT_CRC_BITS-1:0]  o_rac_crc,
    output logic                              o_rac_status,
    output logic                              o_rst_wdg,
    output logic                              o_com_err
);
    import owt_pkg::*;

    owt_rx_state_e           state;
    logic                    line_edge;
    logic                    line_rise;
    logic                    half_strobe;
    logic                    sample_bit;
    logic                    mcst_en;
    logic                    bit_vld;
    logic                    bit_val;
    logic                    invalid;
    logic                    crc_vld;
    logic                    crc_start;
    logic [OWT_CRC_BITS-1:0] crc;
    logic                    frame_done;
    logic                    frame_bad;

    owt_line_sampler u_line_sampler (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_owt_rx      (i_owt_rx),
        .i_state       (state),
        .o_edge        (line_edge),
        .o_rise        (line_rise),
        .o_half_strobe (half_strobe),
        .o_sample_bit  (sample_bit)
    );

    owt_mcst_decoder u_mcst_decoder (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_mcst_en     (mcst_en),
        .i_half_strobe (half_strobe),
        .i_sample_bit  (sample_bit),
        .o_bit_vld     (bit_vld),
        .o_bit_val     (bit_val),
        .o_invalid     (invalid)
    );

    owt_crc8_serial u_crc8_serial (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_vld   (crc_vld),
        .i_start (crc_start),
        .i_bit   (bit_val),
        .o_crc   (crc)
    );

    owt_rx_frame_fsm u_rx_frame_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_edge        (line_edge),
        .i_rise        (line_rise),
        .i_half_strobe (half_strobe),
        .i_sample_bit  (sample_bit),
        .i_bit_vld     (bit_vld),
        .i_bit_val     (bit_val),
        .i_invalid     (invalid),
        .i_crc         (crc),
        .o_state       (state),
        .o_mcst_en     (mcst_en),
        .o_crc_vld     (crc_vld),
        .o_crc_start   (crc_start),
        .o_rac_vld     (o_rac_vld),
        .o_rac_status  (o_rac_status),
        .o_rst_wdg     (o_rst_wdg),
        .o_rac_cmd     (o_rac_cmd),
        .o_rac_data    (o_rac_data),
        .o_rac_crc     (o_rac_crc),
        .o_frame_done  (frame_done),
        .o_frame_bad   (frame_bad)
    );

    owt_com_err_monitor u_com_err_monitor (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_frame_done    (frame_done),
        .i_frame_bad     (frame_bad),
        .i_comerr_mode   (i_comerr_mode),
        .i_comerr_config (i_comerr_config),
        .o_com_err       (o_com_err)
    );

endmodule

`default_nettype wire

// ==== verification/owt_rx_checker.sv ====
// one-wire receiver report checker
`default_nettype none
`timescale 1ns/1ns

module owt_rx_checker (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_rac_vld,
    input  logic [owt_pkg::OWT_CMD_BITS-1:0]  i_rac_cmd,
    input  logic [owt_pkg::OWT_DATA_BITS-1:0] i_rac_data,
    input  logic [owt_pkg::OWT_CRC_BITS-1:0]  i_rac_crc,
    input  logic                              i_rac_status,
    input  logic                              i_rst_wdg,
    input  logic                              i_com_err,
    input  int                                i_frame_idx,
    input  logic                              i_start,
    input  logic                              i_exp_vld,
    input  logic                              i_exp_status,
    input  logic                              i_exp_fields,
    input  logic [owt_pkg::OWT_CMD_BITS-1:0]  i_exp_cmd,
    input  logic [owt_pkg::OWT_DATA_BITS-1:0] i_exp_data,
    input  logic [owt_pkg::OWT_CRC_BITS-1:0]  i_exp_crc,
    input  logic                              i_exp_com_err,
    input  int                                i_wait_limit,
    output logic                              o_busy,
    output int                                o_errors,
    output int                                o_reports
);

    logic waiting  = 1'b0;
    int   wait_cnt = 0;
    int   com_dly  = 0;
    int   errors   = 0;
    int   reports  = 0;

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED frame %0d %s expected 0x%0h actual 0x%0h",
                     i_frame_idx, what, expected, actual);
        end
    endtask

    // outputs are sampled on the falling edge, away from register updates
    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            compare_value("reset o_com_err", 32'd1, 32'(i_com_err));
            compare_value("reset o_rac_vld", 32'd0, 32'(i_rac_vld));
            compare_value("reset o_rst_wdg", 32'd0, 32'(i_rst_wdg));
        end else begin
            if (i_start) begin
                waiting  = i_exp_vld;
                wait_cnt = 0;
            end else if (waiting) begin
                wait_cnt++;
                if (wait_cnt > i_wait_limit) begin
                    errors++;
                    $display("ERROR frame %0d: no o_rac_vld within %0d cycles of frame start",
                             i_frame_idx, i_wait_limit);
                    waiting = 1'b0;
                end
            end
            if (i_rst_wdg && !i_rac_vld) begin
                errors++;
                $display("ERROR frame %0d: o_rst_wdg pulsed without o_rac_vld", i_frame_idx);
            end
            if (i_rac_vld) begin
                if (!waiting) begin
                    errors++;
                    $display("ERROR frame %0d: o_rac_vld when no report was due", i_frame_idx);
                end else begin
                    reports++;
                    waiting = 1'b0;
                    compare_value("o_rac_status", 32'(i_exp_status), 32'(i_rac_status));
                    compare_value("o_rst_wdg", 32'(!i_exp_status), 32'(i_rst_wdg));
                    if (i_exp_fields) begin
                        compare_value("o_rac_cmd", 32'(i_exp_cmd), 32'(i_rac_cmd));
                        compare_value("o_rac_data", 32'(i_exp_data), 32'(i_rac_data));
                        compare_value("o_rac_crc", 32'(i_exp_crc), 32'(i_rac_crc));
                    end
                    // counter and alarm settle two cycles after the report
                    com_dly = 2;
                end
            end else if (com_dly > 0) begin
                com_dly--;
                if (com_dly == 0) begin
                    compare_value("o_com_err", 32'(i_exp_com_err), 32'(i_com_err));
                end
            end
        end
    end

    assign o_busy    = waiting || (com_dly != 0);
    assign o_errors  = errors;
    assign o_reports = reports;

endmodule

`default_nettype wire

// ==== verification/tb_owt_rx_ctrl.sv ====
// one-wire receiver testbench
`default_nettype none
`timescale 1ns/1ns

module tb_owt_rx_ctrl;
    import owt_pkg::*;

    localparam int NUM_FRAMES   = 60;
    localparam int MIN_HALF     = 6;
    localparam int MAX_HALF     = 20;
    localparam int FRAME_HALVES = OWT_SYNC_EDGES + 2 * OWT_TAIL_BITS
                                + 2 * (OWT_CMD_BITS + OWT_DATA_BITS + OWT_CRC_BITS);
    // longest frame plus the longest idle gap
    localparam int MAX_FRAME_CYCLES = (FRAME_HALVES + 6) * MAX_HALF + 32;
    localparam int CYCLE_LIMIT      = 200 + NUM_FRAMES * MAX_FRAME_CYCLES;

    localparam int KIND_GOOD     = 0;
    localparam int KIND_BAD_CRC  = 1;
    localparam int KIND_BAD_END  = 2;
    localparam int KIND_BAD_MCST = 3;
    localparam int KIND_BAD_SYNC = 4;

    logic                     clk;
    logic                     rst_n;
    logic                     owt_rx;
    logic                     comerr_mode;
    logic [3:0]               comerr_config;
    logic                     rac_vld;
    logic [OWT_CMD_BITS-1:0]  rac_cmd;
    logic [OWT_DATA_BITS-1:0] rac_data;
    logic [OWT_CRC_BITS-1:0]  rac_crc;
    logic                     rac_status;
    logic                     rst_wdg;
    logic                     com_err;

    logic                     exp_start;
    logic                     exp_vld;
    logic                     exp_status;
    logic                     exp_fields;
    logic [OWT_CMD_BITS-1:0]  exp_cmd;
    logic [OWT_DATA_BITS-1:0] exp_data;
    logic [OWT_CRC_BITS-1:0]  exp_crc;
    logic                     exp_com_err;
    int                       frame_idx;
    int                       wait_limit;
    int                       err_model;
    int                       cycle_cnt;
    logic                     chk_busy;
    int                       chk_errors;
    int                       chk_reports;
    logic [31:0]              rng_state;

    always begin
        #5;
        clk = ~clk;
    end

    owt_rx_ctrl DUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_owt_rx        (owt_rx),
        .i_comerr_mode   (comerr_mode),
        .i_comerr_config (comerr_config),
        .o_rac_vld       (rac_vld),
        .o_rac_cmd       (rac_cmd),
        .o_rac_data      (rac_data),
        .o_rac_crc       (rac_crc),
        .o_rac_status    (rac_status),
        .o_rst_wdg       (rst_wdg),
        .o_com_err       (com_err)
    );

    owt_rx_checker u_rx_checker (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_rac_vld     (rac_vld),
        .i_rac_cmd     (rac_cmd),
        .i_rac_data    (rac_data),
        .i_rac_crc     (rac_crc),
        .i_rac_status  (rac_status),
        .i_rst_wdg     (rst_wdg),
        .i_com_err     (com_err),
        .i_frame_idx   (frame_idx),
        .i_start       (exp_start),
        .i_exp_vld     (exp_vld),
        .i_exp_status  (exp_status),
        .i_exp_fields  (exp_fields),
        .i_exp_cmd     (exp_cmd),
        .i_exp_data    (exp_data),
        .i_exp_crc     (exp_crc),
        .i_exp_com_err (exp_com_err),
        .i_wait_limit  (wait_limit),
        .o_busy        (chk_busy),
        .o_errors      (chk_errors),
        .o_reports     (chk_reports)
    );

    // ==============================
    // stimulus helpers
    // ==============================
    function automatic int next_rand(input int span);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'({16'd0, rng_state[30:15]} % span);
    endfunction

    // x^8 + x^2 + x + 1, zero start, cmd then data msb first
    function automatic logic [OWT_CRC_BITS-1:0] crc8_of(input logic [OWT_CMD_BITS-1:0] cmd,
                                                       input logic [OWT_DATA_BITS-1:0] data);
        logic [OWT_CMD_BITS+OWT_DATA_BITS-1:0] msg;
        logic [OWT_CRC_BITS-1:0]               crc;
        logic                                  fb;
        int                                    i;
        msg = {cmd, data};
        crc = '0;
        for (i = OWT_CMD_BITS + OWT_DATA_BITS - 1; i >= 0; i--) begin
            fb  = crc[OWT_CRC_BITS-1] ^ msg[i];
            crc = {crc[OWT_CRC_BITS-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ 8'h07;
            end
        end
        return crc;
    endfunction

    // called 1 ns after a rising edge, returns at the same offset
    task automatic hold_line(input logic level, input int cycles);
        owt_rx = level;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // high-low is 1, low-high is 0
    task automatic send_bit(input logic value, input int half);
        hold_line(value, half);
        hold_line(~value, half);
    endtask

    task automatic run_frame(input int n);
        int                       kind;
        int                       half;
        int                       bad_pos;
        int                       add_v;
        int                       sub_v;
        int                       i;
        logic [OWT_CMD_BITS-1:0]  cmd;
        logic [OWT_DATA_BITS-1:0] data;
        logic [OWT_CRC_BITS-1:0]  crc;
        logic [OWT_CRC_BITS-1:0]  crc_tx;
        logic [OWT_TAIL_BITS-1:0] stail;
        logic [OWT_TAIL_BITS-1:0] etail;
        logic                     aborted;
        // first frames walk through every kind, then a random mix
        kind = (n <= KIND_BAD_SYNC) ? n : next_rand(8);
        if (kind > KIND_BAD_SYNC) begin
            kind = KIND_GOOD;
        end
        half          = MIN_HALF + next_rand(MAX_HALF - MIN_HALF + 1);
        cmd           = OWT_CMD_BITS'(next_rand(1 << OWT_CMD_BITS));
        data          = OWT_DATA_BITS'(next_rand(1 << OWT_DATA_BITS));
        comerr_config = 4'(next_rand(16));
        comerr_mode   = 1'(next_rand(2));
        bad_pos       = next_rand(OWT_CMD_BITS);
        crc           = crc8_of(cmd, data);
        crc_tx        = crc;
        if (kind == KIND_BAD_CRC) begin
            crc_tx = crc ^ (OWT_CRC_BITS'(1) << next_rand(OWT_CRC_BITS));
        end
        stail = (kind == KIND_BAD_SYNC) ? 4'b1000 : 4'b1100;
        etail = (kind == KIND_BAD_END) ? 4'b1110 : 4'b1100;

        // leaky counter model
        add_v = int'(OWT_ERR_ADD_TABLE[comerr_config[3:2]]);
        sub_v = int'(OWT_COR_SUB_TABLE[comerr_config[1:0]]);
        if (kind == KIND_GOOD) begin
            err_model = (err_model < sub_v) ? 0 : err_model - sub_v;
        end else if (kind != KIND_BAD_SYNC) begin
            err_model = (err_model + add_v > 31) ? 31 : err_model + add_v;
        end

        frame_idx   = n;
        exp_vld     = (kind != KIND_BAD_SYNC);
        exp_status  = (kind != KIND_GOOD);
        exp_fields  = (kind <= KIND_BAD_END);
        exp_cmd     = cmd;
        exp_data    = data;
        exp_crc     = crc_tx;
        exp_com_err = comerr_mode ? (err_model == 0) : (err_model >= add_v);
        wait_limit  = FRAME_HALVES * half + 16;
        exp_start   = 1'b1;
        hold_line(1'b0, 1);
        exp_start   = 1'b0;

        // preamble of three pulses, then the sync tail
        for (i = 0; i < OWT_SYNC_EDGES / 2; i++) begin
            hold_line(1'b1, half);
            hold_line(1'b0, half);
        end
        for (i = OWT_TAIL_BITS - 1; i >= 0; i--) begin
            hold_line(stail[i], half);
        end
        aborted = (kind == KIND_BAD_SYNC);
        for (i = OWT_CMD_BITS - 1; i >= 0; i--) begin
            if (!aborted) begin
                if ((kind == KIND_BAD_MCST) && (i == bad_pos)) begin
                    // equal halves, rest of frame is not sent
                    hold_line(cmd[i], 2 * half);
                    aborted = 1'b1;
                end else begin
                    send_bit(cmd[i], half);
                end
            end
        end
        if (!aborted) begin
            for (i = OWT_DATA_BITS - 1; i >= 0; i--) begin
                send_bit(data[i], half);
            end
            for (i = OWT_CRC_BITS - 1; i >= 0; i--) begin
                send_bit(crc_tx[i], half);
            end
            for (i = OWT_TAIL_BITS - 1; i >= 0; i--) begin
                hold_line(etail[i], half);
            end
        end
        hold_line(1'b0, 4 * half + next_rand(2 * half + 1));
        while (chk_busy) begin
            hold_line(1'b0, 1);
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        owt_rx        = 1'b0;
        comerr_mode   = 1'b0;
        comerr_config = 4'd0;
        exp_start     = 1'b0;
        exp_vld       = 1'b0;
        exp_status    = 1'b0;
        exp_fields    = 1'b0;
        exp_cmd       = '0;
        exp_data      = '0;
        exp_crc       = '0;
        exp_com_err   = 1'b1;
        frame_idx     = 0;
        wait_limit    = 0;
        err_model     = int'(OWT_ERR_INIT);
        rng_state     = 32'd5;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        hold_line(1'b0, 4 * MAX_HALF);
        for (int n = 0; n < NUM_FRAMES; n++) begin
            run_frame(n);
        end
        hold_line(1'b0, 20);
        $display("frames %0d, reports checked %0d, errors %0d",
                 NUM_FRAMES, chk_reports, chk_errors);
        if (chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run still going after %0d cycles, errors %0d", cycle_cnt, chk_errors);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/owt_pkg.sv
hw/owt_line_sampler.sv
hw/owt_mcst_decoder.sv
hw/owt_crc8_serial.sv
hw/owt_rx_frame_fsm.sv
hw/owt_com_err_monitor.sv
hw/owt_rx_ctrl.sv
verification/owt_rx_checker.sv
verification/tb_owt_rx_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the one-wire receiver testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
    -f filelist.f --top-module tb_owt_rx_ctrl -Mdir obj_dir -o sim_owt_rx
./obj_dir/sim_owt_rx | tee sim.log
if grep -qx "sim passed" sim.log; then
    echo "result: PASS"
else
    echo "result: FAIL"
    exit 1
fi
